/* bench/icache_chk.sv */
// concurrent checks on the L2 request handshake, fill writes and response valids
`timescale 1ns/10ps
`default_nettype none

module icache_chk (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        l2_req_valid,
    input  logic                        l2_req_ready,
    input  icache_pkg::block_addr_t     l2_req_addr,
    input  logic                        l2_resp_valid,
    input  logic                        fill_step,
    input  icache_pkg::index_t          fill_index,
    input  logic                        fill_way,
    input  logic                        fill_valid,
    input  logic                        resp_valid,
    input  icache_pkg::index_t          resp_index,
    input  logic [1:0]                  core_resp_valid_by_way,
    input  logic                        bypass_valid,
    input  logic                        bypass_way
);
    import icache_pkg::*;

    // ways that have completed at least one fill
    logic [NUM_SETS-1:0][1:0]   written_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            written_q <= '0;
        end else if (fill_step && fill_valid) begin
            written_q[fill_index][fill_way] <= 1'b1;
        end
    end

    // request held stable until accepted
    assert property (@(posedge CLK) disable iff (!nRST)
        l2_req_valid && !l2_req_ready |=> l2_req_valid && $stable(l2_req_addr))
        else $error("l2 request dropped or changed before ready");

    // fill starts right after a response and lasts two beats
    assert property (@(posedge CLK) disable iff (!nRST)
        fill_step |-> $past(fill_step) || $past(l2_resp_valid))
        else $error("fill write without a preceding L2 response");

    assert property (@(posedge CLK) disable iff (!nRST)
        fill_step ##1 fill_step |=> !fill_step)
        else $error("fill write longer than one block");

    assert property (@(posedge CLK) disable iff (!nRST)
        resp_valid && core_resp_valid_by_way[0]
            |-> written_q[resp_index][0] || (bypass_valid && !bypass_way))
        else $error("way 0 valid without a write or bypass");

    assert property (@(posedge CLK) disable iff (!nRST)
        resp_valid && core_resp_valid_by_way[1]
            |-> written_q[resp_index][1] || (bypass_valid && bypass_way))
        else $error("way 1 valid without a write or bypass");

endmodule

bind icache icache_chk chk_i (
    .CLK(CLK), .nRST(nRST), .l2_req_valid(l2_req_valid), .l2_req_ready(l2_req_ready),
    .l2_req_addr(l2_req_addr), .l2_resp_valid(l2_resp_valid), .fill_step(fill_step),
    .fill_index(fill_bus.index), .fill_way(fill_bus.way), .fill_valid(fill_last),
    .resp_valid(resp_valid), .resp_index(resp_index),
    .core_resp_valid_by_way(core_resp_valid_by_way),
    .bypass_valid(bypass_valid), .bypass_way(bypass_way)
);

`default_nettype wire

/* bench/icache_scoreboard.sv */
// instruction cache scoreboard comparing responses and L2 requests to the trace
`timescale 1ns/10ps
`default_nettype none

module icache_scoreboard (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        core_req_valid,
    input  logic [1:0]                  core_resp_valid_by_way,
    input  icache_pkg::fetch_t [1:0]    core_resp_instr_by_way,
    input  logic                        core_resp_hit_valid,
    input  logic                        core_resp_hit_way,
    input  logic                        core_resp_miss_valid,
    input  logic                        l2_req_valid,
    input  logic                        l2_req_ready,
    input  icache_pkg::block_addr_t     l2_req_addr,
    input  logic                        sweep,
    input  logic                        entry_end,
    input  int                          entry_id,
    input  icache_pkg::index_t          cur_index,
    input  icache_pkg::beat_t           cur_beat,
    input  icache_pkg::tag_t            cur_tag,
    input  int                          exp_outcome,
    input  icache_pkg::block_addr_t     exp_addr,
    output int                          pass_count,
    output int                          fail_count,
    output int                          error_count
);
    import icache_pkg::*;

    logic   resp_pending;
    logic   first_seen;
    int     first_outcome;
    int     req_count;
    int     entry_errors;
    fetch_t exp_word;
    int     exp_first;

    // byte k of beat b of block A is the low byte of A plus 16b plus k
    function automatic fetch_t rule_word(block_addr_t addr, beat_t b);
        fetch_t w;
        for (int k = 0; k < FETCH_BYTES; k++) begin
            w[k*8 +: 8] = addr[7:0] + 8'(int'(b) * 16 + k);
        end
        return w;
    endfunction

    task automatic report_error();
        entry_errors++;
        error_count++;
    endtask

    initial begin
        pass_count    = 0;
        fail_count    = 0;
        error_count   = 0;
        resp_pending  = 1'b0;
        first_seen    = 1'b0;
        first_outcome = 0;
        req_count     = 0;
        entry_errors  = 0;
    end

    // sample mid cycle where every DUT output and feedback strobe is settled
    always @(negedge CLK) begin
        if (nRST) begin
            if (sweep && resp_pending && core_resp_valid_by_way != 2'b00) begin
                $display("[FAIL] t=%0t core_resp_valid_by_way got %b expected 00",
                         $time, core_resp_valid_by_way);
                report_error();
            end
            if (sweep && l2_req_valid) begin
                $display("[FAIL] t=%0t l2_req_valid got 1 expected 0", $time);
                report_error();
            end

            if (!sweep && core_resp_hit_valid) begin
                exp_word = rule_word({cur_tag, cur_index}, cur_beat);
                if (core_resp_instr_by_way[core_resp_hit_way] != exp_word) begin
                    $display("[FAIL] t=%0t core_resp_instr_by_way got %h expected %h", $time,
                             core_resp_instr_by_way[core_resp_hit_way], exp_word);
                    report_error();
                end
                if (!first_seen) begin
                    first_seen    = 1'b1;
                    first_outcome = int'(core_resp_hit_way);
                end
            end

            if (!sweep && core_resp_miss_valid && !first_seen) begin
                first_seen    = 1'b1;
                first_outcome = 2;
                // cold miss, the set must be empty
                if (exp_outcome == 3 && core_resp_valid_by_way != 2'b00) begin
                    $display("[FAIL] t=%0t core_resp_valid_by_way got %b expected 00",
                             $time, core_resp_valid_by_way);
                    report_error();
                end
            end

            if (l2_req_valid && l2_req_ready) begin
                req_count++;
                if (l2_req_addr != exp_addr) begin
                    $display("[FAIL] t=%0t l2_req_addr got %h expected %h",
                             $time, l2_req_addr, exp_addr);
                    report_error();
                end
            end

            if (entry_end) begin
                exp_first = (exp_outcome >= 2) ? 2 : exp_outcome;
                if (!sweep && first_outcome != exp_first) begin
                    $display("[FAIL] t=%0t first outcome got %0d expected %0d",
                             $time, first_outcome, exp_first);
                    report_error();
                end
                if (!sweep && req_count != ((exp_first == 2) ? 1 : 0)) begin
                    $display("entry %0d issued %0d L2 requests", entry_id, req_count);
                    report_error();
                end
                if (entry_errors == 0) begin
                    pass_count++;
                    $display("test %0d: ok", entry_id);
                end else begin
                    fail_count++;
                    $display("test %0d: failed with %0d errors", entry_id, entry_errors);
                end
                entry_errors = 0;
                first_seen   = 1'b0;
                req_count    = 0;
            end
            resp_pending = core_req_valid;
        end
    end

endmodule

`default_nettype wire

/* bench/icache_tb.sv */
// instruction cache testbench with core and L2 models, trace reader and watchdog
`timescale 1ns/10ps
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    logic                   CLK;
    logic                   nRST;
    logic                   core_req_valid;
    index_t                 core_req_index;
    beat_t                  core_req_block_offset;
    logic [1:0]             core_resp_valid_by_way;
    tag_t [1:0]             core_resp_tag_by_way;
    fetch_t [1:0]           core_resp_instr_by_way;
    logic                   core_resp_hit_valid;
    logic                   core_resp_hit_way;
    logic                   core_resp_miss_valid;
    tag_t                   core_resp_miss_tag;
    logic                   l2_req_valid;
    block_addr_t            l2_req_addr;
    logic                   l2_req_ready;
    logic                   l2_resp_valid;
    block_addr_t            l2_resp_addr;
    block_t                 l2_resp_data;

    // current trace entry, shared with the scoreboard
    logic                   sweep;
    logic                   entry_end;
    int                     entry_id;
    index_t                 cur_index;
    beat_t                  cur_beat;
    tag_t                   cur_tag;
    int                     exp_outcome;
    block_addr_t            exp_addr;
    int                     pass_count;
    int                     fail_count;
    int                     error_count;

    index_t                 tr_index[$];
    beat_t                  tr_beat[$];
    tag_t                   tr_tag[$];
    int                     tr_outcome[$];
    block_addr_t            tr_addr[$];
    logic                   trace_loaded;
    integer                 seed;

    icache icache_i (
        .CLK(CLK), .nRST(nRST),
        .core_req_valid(core_req_valid), .core_req_index(core_req_index),
        .core_req_block_offset(core_req_block_offset),
        .core_resp_valid_by_way(core_resp_valid_by_way),
        .core_resp_tag_by_way(core_resp_tag_by_way),
        .core_resp_instr_by_way(core_resp_instr_by_way),
        .core_resp_hit_valid(core_resp_hit_valid), .core_resp_hit_way(core_resp_hit_way),
        .core_resp_miss_valid(core_resp_miss_valid), .core_resp_miss_tag(core_resp_miss_tag),
        .l2_req_valid(l2_req_valid), .l2_req_addr(l2_req_addr), .l2_req_ready(l2_req_ready),
        .l2_resp_valid(l2_resp_valid), .l2_resp_addr(l2_resp_addr),
        .l2_resp_data(l2_resp_data)
    );

    icache_scoreboard sb_i (
        .CLK(CLK), .nRST(nRST), .core_req_valid(core_req_valid),
        .core_resp_valid_by_way(core_resp_valid_by_way),
        .core_resp_instr_by_way(core_resp_instr_by_way),
        .core_resp_hit_valid(core_resp_hit_valid), .core_resp_hit_way(core_resp_hit_way),
        .core_resp_miss_valid(core_resp_miss_valid),
        .l2_req_valid(l2_req_valid), .l2_req_ready(l2_req_ready), .l2_req_addr(l2_req_addr),
        .sweep(sweep), .entry_end(entry_end), .entry_id(entry_id),
        .cur_index(cur_index), .cur_beat(cur_beat), .cur_tag(cur_tag),
        .exp_outcome(exp_outcome), .exp_addr(exp_addr),
        .pass_count(pass_count), .fail_count(fail_count), .error_count(error_count)
    );

    // ----------------------------------------
    // helpers

    // byte j of block A is the low byte of A plus j
    function automatic block_t make_block(block_addr_t addr);
        block_t blk;
        for (int j = 0; j < BLOCK_BYTES; j++) begin
            blk[j*8 +: 8] = addr[7:0] + 8'(j);
        end
        return blk;
    endfunction

    task automatic load_trace();
        integer                 fd;
        integer                 n;
        logic [8*128-1:0]       line;
        logic [31:0]            f_index;
        logic [31:0]            f_beat;
        logic [31:0]            f_tag;
        logic [31:0]            f_outcome;
        logic [31:0]            f_addr;
        fd = $fopen("bench/icache_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file bench/icache_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                // comment and blank lines do not scan as five fields
                if (n > 0 && $sscanf(line, "%h %h %h %d %h",
                        f_index, f_beat, f_tag, f_outcome, f_addr) == 5) begin
                    tr_index.push_back(index_t'(f_index));
                    tr_beat.push_back(beat_t'(f_beat));
                    tr_tag.push_back(tag_t'(f_tag));
                    tr_outcome.push_back(int'(f_outcome));
                    tr_addr.push_back(block_addr_t'(f_addr));
                end
            end
            $fclose(fd);
            trace_loaded = 1'b1;
        end
    endtask

    // core model, retries a missing lookup until it hits
    task automatic run_lookup(input tag_t tag);
        logic done;
        done = 1'b0;
        while (!done) begin
            core_req_valid = 1'b1;
            @(posedge CLK);
            #1;
            core_req_valid = 1'b0;
            if (core_resp_valid_by_way[0] && core_resp_tag_by_way[0] == tag) begin
                core_resp_hit_valid = 1'b1;
                core_resp_hit_way   = 1'b0;
                done                = 1'b1;
            end else if (core_resp_valid_by_way[1] && core_resp_tag_by_way[1] == tag) begin
                core_resp_hit_valid = 1'b1;
                core_resp_hit_way   = 1'b1;
                done                = 1'b1;
            end else begin
                core_resp_miss_valid = 1'b1;
                core_resp_miss_tag   = tag;
            end
            @(posedge CLK);
            #1;
            core_resp_hit_valid  = 1'b0;
            core_resp_miss_valid = 1'b0;
        end
    endtask

    task automatic finish_entry();
        entry_end = 1'b1;
        @(posedge CLK);
        #1;
        entry_end = 1'b0;
    endtask

    // ----------------------------------------
    // clock, reset and L2 model

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    initial begin
        seed         = 5;
        l2_req_ready = 1'b0;
        forever begin
            @(posedge CLK);
            #1;
            l2_req_ready = 1'($random(seed));
        end
    end

    initial begin : l2_model
        block_addr_t addr;
        l2_resp_valid = 1'b0;
        l2_resp_addr  = '0;
        l2_resp_data  = '0;
        forever begin
            @(negedge CLK);
            if (l2_req_valid && l2_req_ready) begin
                addr = l2_req_addr;
                // accept edge, then three cycles of latency
                repeat (4) @(posedge CLK);
                #1;
                l2_resp_valid = 1'b1;
                l2_resp_addr  = addr;
                l2_resp_data  = make_block(addr);
                @(posedge CLK);
                #1;
                l2_resp_valid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (trace_loaded);
        limit = tr_index.size() * 40 + NUM_SETS * 2 + 20;
        repeat (limit) @(posedge CLK);
        $display("timeout after %0d cycles, the trace did not complete", limit);
        $display("*** FAILED ***");
        $finish;
    end

    // ----------------------------------------
    // main sequence

    initial begin
        nRST                  = 1'b0;
        core_req_valid        = 1'b0;
        core_req_index        = '0;
        core_req_block_offset = '0;
        core_resp_hit_valid   = 1'b0;
        core_resp_hit_way     = 1'b0;
        core_resp_miss_valid  = 1'b0;
        core_resp_miss_tag    = '0;
        sweep                 = 1'b1;
        entry_end             = 1'b0;
        entry_id              = 0;
        cur_index             = '0;
        cur_beat              = '0;
        cur_tag               = '0;
        exp_outcome           = 0;
        exp_addr              = '0;
        trace_loaded          = 1'b0;
        load_trace();
        if (!trace_loaded) begin
            $display("*** FAILED ***");
        end else begin
            repeat (4) @(posedge CLK);
            #1;
            nRST = 1'b1;

            // every set empty after reset, no feedback so the LRU stays put
            for (int s = 0; s < NUM_SETS; s++) begin
                core_req_valid = 1'b1;
                core_req_index = index_t'(s);
                @(posedge CLK);
                #1;
                core_req_valid = 1'b0;
                @(posedge CLK);
                #1;
            end
            finish_entry();
            sweep = 1'b0;

            for (int i = 0; i < tr_index.size(); i++) begin
                entry_id              = i + 1;
                cur_index             = tr_index[i];
                cur_beat              = tr_beat[i];
                cur_tag               = tr_tag[i];
                exp_outcome           = tr_outcome[i];
                exp_addr              = tr_addr[i];
                core_req_index        = tr_index[i];
                core_req_block_offset = tr_beat[i];
                run_lookup(tr_tag[i]);
                // let a fill finish before the next entry
                repeat (3) @(posedge CLK);
                #1;
                finish_entry();
            end

            $display("tests passed: %0d, failed: %0d, errors: %0d",
                     pass_count, fail_count, error_count);
            if (fail_count == 0 && error_count == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/icache_trace.txt */
# columns: index beat tag outcome l2_addr (hex, hex, hex, decimal, hex)
# outcome 0 hit way 0, 1 hit way 1, 2 miss, 3 miss on an empty set
3 0 00000a1 3 00000a13
3 1 00000a1 0 0
3 0 00000a1 0 0
3 0 00000b2 2 00000b23
3 1 00000b2 1 0
3 1 00000a1 0 0
3 0 00000c3 2 00000c33
3 0 00000b2 2 00000b23
3 1 00000c3 1 0
9 1 1abcdef 3 1abcdef9
9 0 1abcdef 0 0
3 0 00000b2 0 0

/* filelist.f */
source/icache_pkg.sv
source/icache_fill_if.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_lru_array.sv
source/icache_fill_counter.sv
source/icache_miss_fsm.sv
source/icache.sv
bench/icache_scoreboard.sv
bench/icache_chk.sv
bench/icache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the instruction cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module icache_tb -f filelist.f \
    && ./obj_dir/Vicache_tb | tee /dev/stderr | grep -qF '*** PASSED ***' \
    && exit 0 \
    || exit 1

/* source/icache.sv */
// blocking two-way instruction cache top with core lookup and L2 miss ports
`timescale 1ns/10ps
`default_nettype none

module icache (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        core_req_valid,
    input  icache_pkg::index_t          core_req_index,
    input  icache_pkg::beat_t           core_req_block_offset,
    output logic [1:0]                  core_resp_valid_by_way,
    output icache_pkg::tag_t [1:0]      core_resp_tag_by_way,
    output icache_pkg::fetch_t [1:0]    core_resp_instr_by_way,
    input  logic                        core_resp_hit_valid,
    input  logic                        core_resp_hit_way,
    input  logic                        core_resp_miss_valid,
    input  icache_pkg::tag_t            core_resp_miss_tag,
    output logic                        l2_req_valid,
    output icache_pkg::block_addr_t     l2_req_addr,
    input  logic                        l2_req_ready,
    input  logic                        l2_resp_valid,
    input  icache_pkg::block_addr_t     l2_resp_addr,
    input  icache_pkg::block_t          l2_resp_data
);
    import icache_pkg::*;

    logic           resp_valid;
    index_t         resp_index;
    beat_t          resp_beat;
    logic [1:0]     tag_valid_by_way;
    tag_t [1:0]     tag_by_way;
    fetch_t [1:0]   word_by_way;
    logic           lru_way;
    beat_t          fill_beat;
    logic           fill_last;
    logic           fill_step;
    logic           bypass_valid;
    logic           bypass_way;
    tag_t           bypass_tag;
    fetch_t         bypass_word;

    icache_fill_if fill_bus ();

    // lookup held for the response cycle
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            resp_valid <= 1'b0;
            resp_index <= '0;
            resp_beat  <= '0;
        end else begin
            resp_valid <= core_req_valid;
            resp_index <= core_req_index;
            resp_beat  <= core_req_block_offset;
        end
    end

    // ----------------------------------------
    // arrays

    icache_tag_array u_tag (
        .CLK(CLK), .nRST(nRST), .rd_en(core_req_valid), .rd_index(core_req_index),
        .rd_valid_by_way(tag_valid_by_way), .rd_tag_by_way(tag_by_way), .fill(fill_bus.array)
    );

    icache_data_array u_data (
        .CLK(CLK), .nRST(nRST), .rd_en(core_req_valid), .rd_index(core_req_index),
        .rd_beat(core_req_block_offset), .rd_word_by_way(word_by_way), .fill(fill_bus.array)
    );

    icache_lru_array u_lru (
        .CLK(CLK), .nRST(nRST), .hit_valid(core_resp_hit_valid), .hit_index(resp_index),
        .hit_way(core_resp_hit_way), .look_index(resp_index), .lru_way(lru_way)
    );

    // ----------------------------------------
    // miss handling

    icache_fill_counter u_cnt (
        .CLK(CLK), .nRST(nRST), .step(fill_step), .beat(fill_beat), .last(fill_last)
    );

    icache_miss_fsm u_miss (
        .CLK(CLK), .nRST(nRST),
        .look_valid(resp_valid), .look_index(resp_index), .look_beat(resp_beat),
        .miss_valid(core_resp_miss_valid), .miss_tag(core_resp_miss_tag), .lru_way(lru_way),
        .l2_req_valid(l2_req_valid), .l2_req_addr(l2_req_addr), .l2_req_ready(l2_req_ready),
        .l2_resp_valid(l2_resp_valid), .l2_resp_addr(l2_resp_addr),
        .l2_resp_data(l2_resp_data),
        .beat(fill_beat), .last(fill_last), .step(fill_step),
        .bypass_valid(bypass_valid), .bypass_way(bypass_way), .bypass_tag(bypass_tag),
        .bypass_word(bypass_word), .fill(fill_bus.fsm)
    );

    // bypass replaces the victim way while its fill is in flight
    always_comb begin
        core_resp_valid_by_way = tag_valid_by_way;
        core_resp_tag_by_way   = tag_by_way;
        core_resp_instr_by_way = word_by_way;
        if (bypass_valid) begin
            core_resp_valid_by_way[bypass_way] = 1'b1;
            core_resp_tag_by_way[bypass_way]   = bypass_tag;
            core_resp_instr_by_way[bypass_way] = bypass_word;
        end
    end

endmodule

`default_nettype wire

/* source/icache_data_array.sv */
// two-way fetch word storage with registered read and per-way fill write
`timescale 1ns/10ps
`default_nettype none

module icache_data_array (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        rd_en,
    input  icache_pkg::index_t          rd_index,
    input  icache_pkg::beat_t           rd_beat,
    output icache_pkg::fetch_t [1:0]    rd_word_by_way,
    icache_fill_if.array                fill
);
    import icache_pkg::*;

    // one word per set, beat and way
    fetch_t [1:0] data_mem [NUM_SETS][FILL_BEATS];

    // ----------------------------------------
    // read port

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            rd_word_by_way <= '0;
        end else if (rd_en) begin
            rd_word_by_way <= data_mem[rd_index][rd_beat];
        end
    end

    // ----------------------------------------
    // write port

    always_ff @(posedge CLK) begin
        if (fill.wr_en) begin
            data_mem[fill.index][fill.beat][fill.way] <= fill.word;
        end
    end

endmodule

`default_nettype wire

/* source/icache_fill_counter.sv */
// beat counter that walks the block beats during a fill
`timescale 1ns/10ps
`default_nettype none

module icache_fill_counter (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                step,
    output icache_pkg::beat_t   beat,
    output logic                last
);
    import icache_pkg::*;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            beat <= '0;
        end else if (step) begin
            // wrap back to beat 0 after the final beat
            beat <= last ? '0 : beat + beat_t'(1);
        end
    end

    assign last = (beat == beat_t'(FILL_BEATS - 1));

endmodule

`default_nettype wire

/* source/icache_fill_if.sv */
// array write bus from the miss handler into the tag and data arrays
`timescale 1ns/10ps
`default_nettype none

interface icache_fill_if;
    import icache_pkg::*;

    logic   wr_en;
    logic   way;
    index_t index;
    beat_t  beat;
    tag_t   tag;
    // only set on the final beat of a block
    logic   valid;
    fetch_t word;

    modport fsm (
        output wr_en, way, index, beat, tag, valid, word
    );

    modport array (
        input wr_en, way, index, beat, tag, valid, word
    );

endinterface

`default_nettype wire

/* source/icache_lru_array.sv */
// per-set LRU bits, set by hit feedback and read for victim selection
`timescale 1ns/10ps
`default_nettype none

module icache_lru_array (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                hit_valid,
    input  icache_pkg::index_t  hit_index,
    input  logic                hit_way,
    input  icache_pkg::index_t  look_index,
    output logic                lru_way
);
    import icache_pkg::*;

    logic [NUM_SETS-1:0] lru_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            lru_q <= '0;
        end else if (hit_valid) begin
            // the way not hit becomes the victim
            lru_q[hit_index] <= ~hit_way;
        end
    end

    // combinational read for miss capture
    assign lru_way = lru_q[look_index];

endmodule

`default_nettype wire

/* source/icache_miss_fsm.sv */
// miss handler with L2 request, block buffer, array fill and response bypass
`timescale 1ns/10ps
`default_nettype none

module icache_miss_fsm (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        look_valid,
    input  icache_pkg::index_t          look_index,
    input  icache_pkg::beat_t           look_beat,
    input  logic                        miss_valid,
    input  icache_pkg::tag_t            miss_tag,
    input  logic                        lru_way,
    output logic                        l2_req_valid,
    output icache_pkg::block_addr_t     l2_req_addr,
    input  logic                        l2_req_ready,
    input  logic                        l2_resp_valid,
    input  icache_pkg::block_addr_t     l2_resp_addr,
    input  icache_pkg::block_t          l2_resp_data,
    input  icache_pkg::beat_t           beat,
    input  logic                        last,
    output logic                        step,
    output logic                        bypass_valid,
    output logic                        bypass_way,
    output icache_pkg::tag_t            bypass_tag,
    output icache_pkg::fetch_t          bypass_word,
    icache_fill_if.fsm                  fill
);
    import icache_pkg::*;

    miss_state_t                state_q, state_d;
    index_t                     miss_index_q;
    tag_t                       miss_tag_q;
    logic                       miss_way_q;
    fetch_t [FILL_BEATS-1:0]    block_buf_q;
    block_addr_t                miss_addr;
    logic                       capture;
    logic                       resp_match;

    assign miss_addr  = {miss_tag_q, miss_index_q};
    // blocking cache, so feedback outside IDLE is dropped
    assign capture    = (state_q == IDLE) & miss_valid;
    // stale responses for other blocks are ignored
    assign resp_match = (state_q == WAIT_L2) & l2_resp_valid & (l2_resp_addr == miss_addr);

    // ----------------------------------------
    // state register

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (capture) state_d = REQUEST;
            REQUEST: if (l2_req_ready) state_d = WAIT_L2;
            WAIT_L2: if (resp_match) state_d = FILL;
            FILL:    if (last) state_d = DELAY;
            DELAY:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // ----------------------------------------
    // miss register and block buffer

    always_ff @(posedge CLK) begin
        if (capture) begin
            miss_index_q <= look_index;
            miss_tag_q   <= miss_tag;
            miss_way_q   <= lru_way;
        end
        if (resp_match) begin
            block_buf_q <= l2_resp_data;
        end
    end

    assign l2_req_valid = (state_q == REQUEST);
    assign l2_req_addr  = miss_addr;

    // one beat per cycle into the victim way
    assign fill.wr_en = (state_q == FILL);
    assign fill.way   = miss_way_q;
    assign fill.index = miss_index_q;
    assign fill.beat  = beat;
    assign fill.tag   = miss_tag_q;
    assign fill.valid = last;
    assign fill.word  = block_buf_q[beat];
    assign step       = fill.wr_en;

    // lookups of the block in flight read from the buffer
    assign bypass_valid = look_valid & ((state_q == FILL) | (state_q == DELAY))
                        & (look_index == miss_index_q);
    assign bypass_way   = miss_way_q;
    assign bypass_tag   = miss_tag_q;
    assign bypass_word  = block_buf_q[look_beat];

endmodule

`default_nettype wire

/* source/icache_pkg.sv */
// instruction cache package with geometry constants, width types and miss states
`default_nettype none

package icache_pkg;

    // ----------------------------------------
    // geometry

    localparam int NUM_SETS    = 16;
    localparam int FETCH_BYTES = 16;
    localparam int BLOCK_BYTES = 32;
    localparam int FILL_BEATS  = BLOCK_BYTES / FETCH_BYTES;
    localparam int TAG_BITS    = 25;

    // ----------------------------------------
    // width types

    typedef logic [$clog2(NUM_SETS)-1:0]            index_t;
    typedef logic [$clog2(FILL_BEATS)-1:0]          beat_t;
    typedef logic [TAG_BITS-1:0]                    tag_t;
    // tag sits above the index
    typedef logic [TAG_BITS+$clog2(NUM_SETS)-1:0]   block_addr_t;
    typedef logic [FETCH_BYTES*8-1:0]               fetch_t;
    // beat 0 lives in the low half
    typedef logic [BLOCK_BYTES*8-1:0]               block_t;

    // miss handler states
    typedef enum logic [2:0] {
        IDLE,
        REQUEST,
        WAIT_L2,
        FILL,
        DELAY
    } miss_state_t;

endpackage

`default_nettype wire

/* source/icache_tag_array.sv */
// two-way tag and valid storage with registered read and per-way fill write
`timescale 1ns/10ps
`default_nettype none

module icache_tag_array (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    rd_en,
    input  icache_pkg::index_t      rd_index,
    output logic [1:0]              rd_valid_by_way,
    output icache_pkg::tag_t [1:0]  rd_tag_by_way,
    icache_fill_if.array            fill
);
    import icache_pkg::*;

    logic [NUM_SETS-1:0][1:0]   valid_q;
    tag_t [1:0]                 tag_mem [NUM_SETS];

    // valid bits and their read register
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_q         <= '0;
            rd_valid_by_way <= '0;
        end else begin
            if (rd_en) begin
                rd_valid_by_way <= valid_q[rd_index];
            end
            // early beats drop the valid bit of the victim way
            if (fill.wr_en) begin
                valid_q[fill.index][fill.way] <= fill.valid;
            end
        end
    end

    // tag storage
    always_ff @(posedge CLK) begin
        if (rd_en) begin
            rd_tag_by_way <= tag_mem[rd_index];
        end
        if (fill.wr_en && fill.valid) begin
            tag_mem[fill.index][fill.way] <= fill.tag;
        end
    end

endmodule

`default_nettype wire
